// ==== arb_pkg.sv ====
/* Shared sizes and command/response types of the four-requester scratchpad port.
   The command struct packs MSB first as write, hold, addr, wdata. */
`default_nettype none

package arb_pkg;

  // ------------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------------
  // Number of requesters sharing the port
  localparam int num_req = 4;

  // Scratchpad geometry, depth must equal 2**addr_w
  localparam int addr_w = 4;
  localparam int mem_depth = 16;
  localparam int data_w = 16;

  // Hold length gives the extra service cycles after acceptance
  localparam int hold_w = 2;

  // ------------------------------------------------------------------------
  // Command and response words
  // ------------------------------------------------------------------------
  // One command per requester, held stable while its request is high
  typedef struct packed {
    logic              write;
    logic [hold_w-1:0] hold;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } port_cmd_t;

  // Done is a one-hot pulse, rdata is valid while done is high
  typedef struct packed {
    logic [num_req-1:0] done;
    logic [data_w-1:0]  rdata;
  } port_rsp_t;

endpackage

`default_nettype wire

// ==== lru_arbiter.sv ====
/* Matrix LRU arbiter, grant is combinational from request.
   Priority moves only on prio_update; after reset lower indices win. */
`timescale 1ns/10ps
`default_nettype none

module lru_arbiter import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               prio_update,
  input  logic [num_req-1:0] request,
  output logic [num_req-1:0] grant
);

  // ------------------------------------------------------------------------
  // Priority matrix
  // ------------------------------------------------------------------------
  // prio[i][j] set means requester i was served less recently than j,
  // so i outranks j when both are requesting
  logic [num_req-1:0][num_req-1:0] prio;
  logic [num_req-1:0]              can_grant;

  for (genvar i = 0; i < num_req; i++) begin : g_row
    for (genvar j = 0; j < num_req; j++) begin : g_col
      if (i < j) begin : g_upper
        // Only the upper triangle holds state
        logic cell_q;

        always_ff @(posedge clk) begin
          if (!rst_n) begin
            // Reset order has the lower index ahead
            cell_q <= 1'b1;
          end else if (prio_update) begin
            // Winner row clears, winner column sets
            if (grant[i]) begin
              cell_q <= 1'b0;
            end else if (grant[j]) begin
              cell_q <= 1'b1;
            end
          end
        end

        assign prio[i][j] = cell_q;
      end else if (i > j) begin : g_lower
        // Lower triangle mirrors the upper one
        assign prio[i][j] = ~prio[j][i];
      end else begin : g_diag
        // A requester never blocks itself
        assign prio[i][j] = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Grant search
  // ------------------------------------------------------------------------
  // A requester may win if every other active requester ranks below it
  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      can_grant[i] = 1'b1;
      for (int j = 0; j < num_req; j++) begin
        can_grant[i] = can_grant[i] & (~request[j] | prio[i][j]);
      end
    end
  end

  assign grant = request & can_grant;

  // The matrix is a total order, so at most one requester can win
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant))
    else $error("lru_arbiter granted more than one requester");

  // No deadlock in the order, some requester always wins
  assert property (@(posedge clk) disable iff (!rst_n)
    (|request) |-> (|grant))
    else $error("lru_arbiter left an active request without a grant");

endmodule

`default_nettype wire

// ==== grant_fsm.sv ====
/* Accepts one grant at a time and holds it until the hold timer expires.
   Done comes one cycle after expiry, then one idle cycle precedes the next accept. */
`timescale 1ns/10ps
`default_nettype none

module grant_fsm import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] grant,
  input  logic               expired,
  output logic               accept,
  output logic               load,
  output logic [num_req-1:0] accepted_grant,
  output logic [num_req-1:0] done_pulse,
  output logic               busy
);

  typedef enum logic [1:0] {
    idle,
    serve,
    finish
  } state_t;

  state_t state;

  // ------------------------------------------------------------------------
  // Acceptance
  // ------------------------------------------------------------------------
  // Accept is combinational in idle so the winner is taken on this edge
  assign accept = (state == idle) && (|grant);

  // The timer reloads on every accepted job
  assign load = accept;

  // ------------------------------------------------------------------------
  // State register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= idle;
      accepted_grant <= '0;
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            // Remember the winner for the whole job
            accepted_grant <= grant;
            state          <= serve;
          end
        end
        serve: begin
          // Stay while the timer still counts
          if (expired) begin
            state <= finish;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Done goes back only to the requester that owns the job
  assign done_pulse = (state == finish) ? accepted_grant : '0;

  // Busy covers serve and finish, low for the single idle cycle
  assign busy = (state != idle);

  // Done lasts one cycle and is never repeated back to back
  assert property (@(posedge clk) disable iff (!rst_n)
    (|done_pulse) |-> (state == finish) ##1 (done_pulse == '0))
    else $error("grant_fsm done pulse outside finish or longer than one cycle");

  // An accepted job always moves the port into service
  assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> (state == idle) ##1 (state == serve))
    else $error("grant_fsm accepted a grant outside idle");

endmodule

`default_nettype wire

// ==== hold_timer.sv ====
/* Down-counter for the service period, expired is high while the count is zero.
   Expects load only after the previous count has run out. */
`timescale 1ns/10ps
`default_nettype none

module hold_timer import arb_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  logic [hold_w-1:0] hold,
  output logic              expired
);

  logic [hold_w-1:0] count;

  // Capture the hold length, then count down and park at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= hold;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Zero count means the service period is over
  assign expired = (count == '0);

  // A new job must not cut short the one still being timed
  assert property (@(posedge clk) disable iff (!rst_n)
    load |-> (count == '0))
    else $error("hold_timer reloaded while still counting");

endmodule

`default_nettype wire

// ==== scratch_mem.sv ====
/* Single-port scratchpad with reset-cleared contents and a registered read word.
   Grant must be one-hot on accept; rdata holds until the next read. */
`timescale 1ns/10ps
`default_nettype none

module scratch_mem import arb_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          accept,
  input  logic      [num_req-1:0]       grant,
  input  port_cmd_t [num_req-1:0]       cmd,
  output logic      [hold_w-1:0]        sel_hold,
  output logic      [data_w-1:0]        rdata
);

  port_cmd_t         sel_cmd;
  logic              pend_q;
  logic              write_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [data_w-1:0] mem [mem_depth];

  // ------------------------------------------------------------------------
  // Command select
  // ------------------------------------------------------------------------
  // One-hot mux over the requester commands
  always_comb begin
    sel_cmd = '0;
    for (int i = 0; i < num_req; i++) begin
      if (grant[i]) begin
        sel_cmd = cmd[i];
      end
    end
  end

  // The timer needs the hold length in the accept cycle itself
  assign sel_hold = sel_cmd.hold;

  // ------------------------------------------------------------------------
  // Command latch
  // ------------------------------------------------------------------------
  // Pending marks the one edge where the latched command executes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      write_q <= sel_cmd.write;
      addr_q  <= sel_cmd.addr;
      wdata_q <= sel_cmd.wdata;
    end
  end

  // ------------------------------------------------------------------------
  // Storage and read register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < mem_depth; k++) begin
        mem[k] <= '0;
      end
      rdata <= '0;
    end else if (pend_q) begin
      if (write_q) begin
        mem[addr_q] <= wdata_q;
      end else begin
        rdata <= mem[addr_q];
      end
    end
  end

  // Latching a blend of two commands would corrupt the job
  assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> $onehot(grant))
    else $error("scratch_mem accept without a one-hot grant");

endmodule

`default_nettype wire

// ==== shared_port_top.sv ====
/* Four-requester scratchpad port, one job in flight and no back-pressure.
   Requesters hold request and command until their done bit, then drop request. */
`timescale 1ns/10ps
`default_nettype none

module shared_port_top import arb_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic      [num_req-1:0] request,
  input  port_cmd_t [num_req-1:0] cmd,
  output port_rsp_t               rsp,
  output logic                    busy
);

  logic [num_req-1:0] grant;
  logic [num_req-1:0] done_pulse;
  logic               accept;
  logic               load;
  logic               expired;
  logic [hold_w-1:0]  sel_hold;
  logic [data_w-1:0]  rdata;

  // ------------------------------------------------------------------------
  // Arbitration and control
  // ------------------------------------------------------------------------
  // Priority only moves on an accepted grant
  lru_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .prio_update (accept),
    .request     (request),
    .grant       (grant)
  );

  // The accepted winner only matters inside the FSM, where it shapes done
  grant_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .grant          (grant),
    .expired        (expired),
    .accept         (accept),
    .load           (load),
    .accepted_grant (),
    .done_pulse     (done_pulse),
    .busy           (busy)
  );

  // Hold length arrives from the selected command in the accept cycle
  hold_timer u_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .hold    (sel_hold),
    .expired (expired)
  );

  // ------------------------------------------------------------------------
  // Scratchpad and response
  // ------------------------------------------------------------------------
  scratch_mem u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .accept   (accept),
    .grant    (grant),
    .cmd      (cmd),
    .sel_hold (sel_hold),
    .rdata    (rdata)
  );

  assign rsp.done  = done_pulse;
  assign rsp.rdata = rdata;

endmodule

`default_nettype wire

// ==== tb_shared_port.sv ====
/* Random-traffic testbench for the shared scratchpad port, checked against an LRU and memory model.
   Requesters hold request and command until their done bit, then drop request in that cycle. */
`timescale 1ns/10ps
`default_nettype none

module tb_shared_port import arb_pkg::*; ();

  // ------------------------------------------------------------------------
  // Run length and limits
  // ------------------------------------------------------------------------
  localparam int clk_period = 8;
  localparam int n_jobs = 64;
  localparam int full_jobs = 8;
  // Longest job is max hold, plus done and the idle cycle, plus accept
  localparam int max_job_cycles = (1 << hold_w) + 3;
  localparam int watchdog_cycles = 10 + 2 * (n_jobs + num_req) * max_job_cycles + 100;

  logic                    clk;
  logic                    rst_n;
  logic      [num_req-1:0] request;
  port_cmd_t [num_req-1:0] cmd;
  port_rsp_t               rsp;
  logic                    busy;

  // Model and bookkeeping state
  logic [31:0]        seed;
  int                 err_count;
  int                 jobs_done;
  int                 mode;
  int                 single_step;
  logic               single_live;
  int                 lru_order[$];
  logic [data_w-1:0]  model_mem [mem_depth];
  logic               job_active;
  int                 job_owner;
  int                 job_age;
  port_cmd_t          job_cmd;
  logic               busy_prev;
  logic               after_done;
  logic               expect_busy;
  logic [num_req-1:0] just_done;

  shared_port_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (request),
    .cmd     (cmd),
    .rsp     (rsp),
    .busy    (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Ends a run that stalls, for example a request that never gets done
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired: the port stopped completing jobs");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits are the better ones, the low bits cycle quickly
  function automatic port_cmd_t make_cmd(input logic [31:0] r);
    port_cmd_t c;
    c.write = r[28];
    c.hold  = r[30:29];
    c.addr  = r[27:24];
    c.wdata = r[23:8];
    return c;
  endfunction

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic check_idle(input string when);
    if (busy !== 1'b0 || rsp.done !== '0 || rsp.rdata !== '0) begin
      report_error($sformatf("port not idle %s, busy %b done %b rdata %h",
                             when, busy, rsp.done, rsp.rdata));
    end
  endtask

  // ------------------------------------------------------------------------
  // Output checks, run at every falling edge before new inputs are driven
  // ------------------------------------------------------------------------
  task automatic check_outputs();
    int                 found;
    logic               saw_done;
    logic [num_req-1:0] exp_done;
    saw_done  = 1'b0;
    just_done = '0;
    // The cycle after done is the single idle cycle
    if (after_done && (busy !== 1'b0 || rsp.done !== '0)) begin
      report_error($sformatf("after done busy %b done %b, expected idle", busy, rsp.done));
    end
    if (expect_busy && busy !== 1'b1) begin
      report_error("a pending request was not accepted in the idle cycle");
    end
    // Busy rising marks a new job, the model picks the winner here
    if (busy === 1'b1 && busy_prev === 1'b0) begin
      found = -1;
      for (int k = 0; k < lru_order.size(); k++) begin
        if (found < 0 && request[lru_order[k]]) begin
          found = k;
        end
      end
      if (found < 0) begin
        report_error("busy rose with no request pending");
      end else begin
        job_owner  = lru_order[found];
        lru_order.delete(found);
        lru_order.push_back(job_owner);
        job_cmd    = cmd[job_owner];
        job_active = 1'b1;
        job_age    = 0;
      end
    end
    if (rsp.done !== '0) begin
      if (!job_active) begin
        report_error($sformatf("done %b with no job in service", rsp.done));
      end else begin
        saw_done = 1'b1;
        exp_done = '0;
        exp_done[job_owner] = 1'b1;
        if (rsp.done !== exp_done) begin
          report_error($sformatf("done %b, expected %b", rsp.done, exp_done));
        end
        if (job_age != job_cmd.hold + 1) begin
          report_error($sformatf("done after %0d cycles, expected %0d", job_age, job_cmd.hold + 1));
        end
        // Fresh LRU order serves the fully loaded port round robin
        if (jobs_done < full_jobs && rsp.done !== (4'b0001 << (jobs_done % num_req))) begin
          report_error($sformatf("contention job %0d went to done %b", jobs_done, rsp.done));
        end
        if (job_cmd.write) begin
          model_mem[job_cmd.addr] = job_cmd.wdata;
        end else if (rsp.rdata !== model_mem[job_cmd.addr]) begin
          report_error($sformatf("read of word %0d gave %h, expected %h",
                                 job_cmd.addr, rsp.rdata, model_mem[job_cmd.addr]));
        end
        // Directed write then read on requester 2
        if (single_live) begin
          if (rsp.done !== 4'b0100) begin
            report_error($sformatf("single requester job done %b", rsp.done));
          end
          if (!job_cmd.write && rsp.rdata !== 16'ha5c3) begin
            report_error($sformatf("single read gave %h, expected a5c3", rsp.rdata));
          end
          single_live = 1'b0;
        end
        // The requester drops its level in the done cycle
        request[job_owner]   = 1'b0;
        just_done[job_owner] = 1'b1;
        job_active           = 1'b0;
        jobs_done++;
      end
    end else if (job_active && job_age > job_cmd.hold + 1) begin
      report_error($sformatf("no done for requester %0d after %0d cycles", job_owner, job_age));
      job_active = 1'b0;
    end
    if (job_active) begin
      job_age++;
    end
    after_done = saw_done;
    busy_prev  = busy;
  endtask

  // ------------------------------------------------------------------------
  // Stimulus: contention, then one requester, then random traffic
  // ------------------------------------------------------------------------
  task automatic drive_requests();
    port_cmd_t c;
    if (mode == 0 && jobs_done >= full_jobs) mode = 1;
    if (mode == 1 && single_step == 2 && request == '0 && !single_live) mode = 2;
    if (mode == 2 && jobs_done >= n_jobs) mode = 3;
    for (int i = 0; i < num_req; i++) begin
      if (!request[i] && !just_done[i]) begin
        seed = lcg_next(seed);
        c    = make_cmd(seed);
        seed = lcg_next(seed);
        if (mode == 0 || (mode == 2 && seed[31])) begin
          cmd[i]     = c;
          request[i] = 1'b1;
        end
      end
    end
    // Requester 2 alone, only once the port has drained
    if (mode == 1 && request == '0 && just_done == '0 && single_step < 2) begin
      c.write = (single_step == 0);
      c.hold  = (single_step == 0) ? 2'd1 : 2'd2;
      c.addr  = 4'd5;
      c.wdata = (single_step == 0) ? 16'ha5c3 : 16'h0000;
      cmd[2]      = c;
      request[2]  = 1'b1;
      single_live = 1'b1;
      single_step++;
    end
    expect_busy = (busy === 1'b0) && (request != '0);
  endtask

  initial begin
    rst_n       = 1'b0;
    request     = '0;
    cmd         = '0;
    seed        = 32'h8d87d487;
    err_count   = 0;
    jobs_done   = 0;
    mode        = 0;
    single_step = 0;
    single_live = 1'b0;
    job_active  = 1'b0;
    job_owner   = 0;
    job_age     = 0;
    job_cmd     = '0;
    busy_prev   = 1'b0;
    after_done  = 1'b0;
    expect_busy = 1'b0;
    just_done   = '0;
    lru_order   = {0, 1, 2, 3};
    for (int i = 0; i < mem_depth; i++) begin
      model_mem[i] = '0;
    end
    repeat (10) begin
      @(negedge clk);
      check_idle("during reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle("just after reset");
    while (mode != 3 || request != '0 || job_active) begin
      @(negedge clk);
      check_outputs();
      drive_requests();
    end
    // One more cycle covers the idle cycle after the last done
    @(negedge clk);
    check_outputs();
    $display("Run complete: %0d jobs, %0d errors", jobs_done, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
arb_pkg.sv
lru_arbiter.sv
grant_fsm.sv
hold_timer.sv
scratch_mem.sv
shared_port_top.sv
tb_shared_port.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the shared port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_shared_port \
  -f list.f \
  --Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
